// ==== sim.f ====
+incdir+verilog
verilog/dr_cfg_pkg.sv
verilog/dr_beam_pkg.sv
verilog/rbg_counter.sv
verilog/beam_mac.sv
verilog/beam_power_acc.sv
verilog/beam_select.sv
verilog/pusch_dr_top.sv
dv/pusch_dr_sva.sv
dv/pusch_dr_checker.sv
dv/pusch_dr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the PUSCH DR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f sim.f --top-module pusch_dr_tb -Mdir obj_dir -o pusch_dr_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/pusch_dr_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== dv/pusch_dr_tb.sv ====
// PUSCH dimension-reduction testbench
// drives symbol cases from a table into the DUT, the checker
// module compares, this top gives the verdict
`include "pusch_dr_params.svh"

module pusch_dr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dr_cfg_pkg::*;
    import dr_beam_pkg::*;

    localparam int N_ROWS    = 8;
    localparam int MODE_RAND = 0;    // $random samples
    localparam int MODE_IMP  = 1;    // one antenna, constant
    localparam int MODE_ROW  = 2;    // one hadamard row

    typedef struct {
        int size;        // rbg size code
        int nre;         // REs in the symbol
        bit gap;         // idle cycles between REs
        int mode;
        int sel;         // antenna or hadamard row
        int exp_best;    // -1 when any beam may win
    } row_t;

    row_t       tbl [N_ROWS];
    int         seed = 7575;
    logic       clk = 1'b0;
    logic       reset;
    logic       iq_vld;
    logic       iq_sop;
    ant_vec_t   iq_data;
    rbg_size_t  rbg_size;
    logic       beam_vld;
    beam_vec_t  beam_data;
    logic       rbg_start;
    logic       rbg_end;
    rbg_idx_t   rbg_idx;
    logic       pwr_vld;
    pwr_vec_t   beam_pwr;
    beam_idx_t  best_beam;
    rbg_idx_t   pwr_rbg_idx;
    int         row_id;
    logic       row_done;
    logic       all_done;
    int         exp_best;
    int         err_cnt;

    always #2 clk = ~clk;    // 4 ns period

    pusch_dr_top dut_i (
        .i_clk (clk), .i_reset (reset), .i_iq_vld (iq_vld), .i_iq_sop (iq_sop),
        .i_iq_data (iq_data), .i_rbg_size (rbg_size),
        .o_beam_vld (beam_vld), .o_beam_data (beam_data), .o_rbg_start (rbg_start),
        .o_rbg_end (rbg_end), .o_rbg_idx (rbg_idx), .o_pwr_vld (pwr_vld),
        .o_beam_pwr (beam_pwr), .o_best_beam (best_beam), .o_pwr_rbg_idx (pwr_rbg_idx)
    );

    pusch_dr_checker chk_i (
        .i_clk (clk), .i_reset (reset), .i_iq_vld (iq_vld), .i_iq_sop (iq_sop),
        .i_iq_data (iq_data), .i_rbg_size (rbg_size),
        .i_beam_vld (beam_vld), .i_beam_data (beam_data), .i_rbg_start (rbg_start),
        .i_rbg_end (rbg_end), .i_rbg_idx (rbg_idx), .i_pwr_vld (pwr_vld),
        .i_beam_pwr (beam_pwr), .i_best_beam (best_beam), .i_pwr_rbg_idx (pwr_rbg_idx),
        .i_row_id (row_id), .i_row_done (row_done), .i_exp_best (exp_best),
        .i_all_done (all_done), .o_err_cnt (err_cnt)
    );

    // one RE worth of antenna samples
    function automatic ant_vec_t make_re(input int mode, input int sel);
        ant_vec_t v;
        int       w;
        for (int a = 0; a < `DR_ANT; a++) begin
            w = ($countones(sel & a) % 2 == 1) ? -1 : 1;
            case (mode)
                MODE_IMP: begin
                    v[a].i = (a == sel) ? 16'sd12000 : 16'sd0;
                    v[a].q = (a == sel) ? -16'sd7000 : 16'sd0;
                end
                MODE_ROW: begin
                    v[a].i = 16'(w * 3000);
                    v[a].q = 16'(w * -1500);
                end
                default: begin
                    v[a].i = 16'($random(seed));
                    v[a].q = 16'($random(seed));
                end
            endcase
        end
        return v;
    endfunction

    task automatic watchdog(input int total_re);
        int limit;
        limit = total_re * 4 + N_ROWS * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog: run not finished after %0d cycles, stopped", limit);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // ----------------------------------------------------------
    // one symbol: sop on the first RE, drain, then row done
    // ----------------------------------------------------------
    task automatic run_row(input int r);
        int gap_len;
        row_id   = r;
        exp_best = tbl[r].exp_best;
        rbg_size = rbg_size_t'(tbl[r].size);
        for (int k = 0; k < tbl[r].nre; k++) begin
            @(negedge clk);
            iq_vld  = 1'b1;
            iq_sop  = (k == 0);
            iq_data = make_re(tbl[r].mode, tbl[r].sel);
            if (tbl[r].gap && (k % 7 == 3)) begin
                gap_len = 1 + ($random(seed) & 3);
                repeat (gap_len) begin
                    @(negedge clk);
                    iq_vld  = 1'b0;
                    iq_sop  = 1'b0;
                    iq_data = make_re(MODE_RAND, 0);    // junk on idle
                end
            end
        end
        @(negedge clk);
        iq_vld = 1'b0;
        iq_sop = 1'b0;
        repeat (6) @(negedge clk);
        row_done = 1'b1;
        @(negedge clk);
        row_done = 1'b0;
    endtask

    initial begin
        int total_re;
        reset    = 1'b1;
        iq_vld   = 1'b0;
        iq_sop   = 1'b0;
        iq_data  = '0;
        rbg_size = '0;
        row_id   = 0;
        row_done = 1'b0;
        all_done = 1'b0;
        exp_best = -1;
        //        size nre  gap  mode       sel best
        tbl[0] = '{0,  96,  0,   MODE_RAND, 0,  -1};
        tbl[1] = '{1,  200, 1,   MODE_RAND, 0,  -1};    // partial rbg at end
        tbl[2] = '{2,  192, 0,   MODE_ROW,  2,  2};
        tbl[3] = '{3,  200, 1,   MODE_ROW,  1,  1};
        tbl[4] = '{0,  48,  1,   MODE_IMP,  3,  0};     // all beams tie
        tbl[5] = '{0,  150, 0,   MODE_ROW,  3,  3};
        tbl[6] = '{1,  96,  1,   MODE_RAND, 0,  -1};
        tbl[7] = '{2,  60,  0,   MODE_RAND, 0,  -1};    // no full rbg
        total_re = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total_re += tbl[r].nre;
        end
        fork
            watchdog(total_re);
        join_none
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);    // strobes must stay low here
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        all_done = 1'b1;
        @(negedge clk);
        all_done = 1'b0;
        if (dut_i.sva_i.fail_cnt != 0) begin
            $display("%0d assertion failures on the strobes", dut_i.sva_i.fail_cnt);
        end
        if (err_cnt == 0 && dut_i.sva_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/pusch_dr_checker.sv ====
// PUSCH DR checker
// reference model of framing, beam sums, powers and argmax,
// compared against the DUT outputs on every rising edge
`include "pusch_dr_params.svh"

module pusch_dr_checker (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_iq_vld,
    input  logic                   i_iq_sop,
    input  dr_beam_pkg::ant_vec_t  i_iq_data,
    input  dr_cfg_pkg::rbg_size_t  i_rbg_size,
    input  logic                   i_beam_vld,
    input  dr_beam_pkg::beam_vec_t i_beam_data,
    input  logic                   i_rbg_start,
    input  logic                   i_rbg_end,
    input  dr_cfg_pkg::rbg_idx_t   i_rbg_idx,
    input  logic                   i_pwr_vld,
    input  dr_beam_pkg::pwr_vec_t  i_beam_pwr,
    input  dr_beam_pkg::beam_idx_t i_best_beam,
    input  dr_cfg_pkg::rbg_idx_t   i_pwr_rbg_idx,
    input  int                     i_row_id,
    input  logic                   i_row_done,
    input  int                     i_exp_best,
    input  logic                   i_all_done,
    output int                     o_err_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         row_err = 0;      // counts at the start of the row
    int         row_chk = 0;
    int         re_cnt = 0;
    int         rbg_idx = 0;
    logic       exp_vld = 1'b0;
    logic       exp_first;
    logic       exp_last;
    int         exp_idx;
    int         exp_bi [`DR_BEAM];
    int         exp_bq [`DR_BEAM];
    longint     acc [`DR_BEAM] = '{default: 0};
    longint     exp_pwr [`DR_BEAM];
    int         exp_pidx;
    int         exp_top;
    logic [2:0] pwr_sr = '0;      // report due 3 edges after last RE

    assign o_err_cnt = err_cnt;

    // -1 when popcount(beam & ant) is odd
    function automatic int weight(input int b, input int a);
        return ($countones(b & a) % 2 == 1) ? -1 : 1;
    endfunction

    function automatic int rbg_len(input int code);
        return (code == 0) ? 48 : (code == 1) ? 96 : 192;
    endfunction

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    always @(posedge i_clk) begin
        int     cur_cnt;
        int     si;
        int     sq;
        int     top;
        longint re_pwr;
        if (i_reset) begin
            re_cnt  = 0;
            rbg_idx = 0;
            exp_vld = 1'b0;
            pwr_sr  = '0;
        end else begin
            // ------------------------------------------------------
            // outputs due from the previous edges
            // ------------------------------------------------------
            check_value("o_beam_vld", i_beam_vld, exp_vld);
            check_value("o_rbg_start", i_rbg_start, exp_vld & exp_first);
            check_value("o_rbg_end", i_rbg_end, exp_vld & exp_last);
            if (exp_vld) begin
                check_value("o_rbg_idx", i_rbg_idx, exp_idx);
                for (int b = 0; b < `DR_BEAM; b++) begin
                    check_value($sformatf("o_beam_data[%0d].i", b), i_beam_data[b].i, exp_bi[b]);
                    check_value($sformatf("o_beam_data[%0d].q", b), i_beam_data[b].q, exp_bq[b]);
                end
            end
            check_value("o_pwr_vld", i_pwr_vld, pwr_sr[2]);
            if (pwr_sr[2]) begin
                for (int b = 0; b < `DR_BEAM; b++) begin
                    check_value($sformatf("o_beam_pwr[%0d]", b), i_beam_pwr[b], exp_pwr[b]);
                end
                check_value("o_best_beam", i_best_beam, exp_top);
                check_value("o_pwr_rbg_idx", i_pwr_rbg_idx, exp_pidx);
                if (i_exp_best >= 0) begin
                    check_value("o_best_beam (table)", i_best_beam, i_exp_best);
                end
            end
            pwr_sr  = {pwr_sr[1:0], 1'b0};
            // ------------------------------------------------------
            // model the RE on the input now
            // ------------------------------------------------------
            exp_vld   = i_iq_vld;
            exp_first = 1'b0;
            exp_last  = 1'b0;
            if (i_iq_vld) begin
                cur_cnt   = i_iq_sop ? 0 : re_cnt;
                exp_idx   = i_iq_sop ? 0 : rbg_idx;
                exp_first = (cur_cnt == 0);
                exp_last  = (cur_cnt == rbg_len(int'(i_rbg_size)) - 1);
                for (int b = 0; b < `DR_BEAM; b++) begin
                    si = 0;
                    sq = 0;
                    for (int a = 0; a < `DR_ANT; a++) begin
                        si += weight(b, a) * int'(i_iq_data[a].i);
                        sq += weight(b, a) * int'(i_iq_data[a].q);
                    end
                    exp_bi[b] = si >>> `DR_SHIFT;
                    exp_bq[b] = sq >>> `DR_SHIFT;
                    re_pwr = longint'(si) * si + longint'(sq) * sq;
                    acc[b] = exp_first ? re_pwr : acc[b] + re_pwr;
                end
                if (exp_last) begin
                    top = 0;
                    for (int b = 1; b < `DR_BEAM; b++) begin
                        if (acc[b] > acc[top]) top = b;    // lowest wins ties
                    end
                    exp_pwr   = acc;
                    exp_top   = top;
                    exp_pidx  = exp_idx;
                    pwr_sr[0] = 1'b1;
                    re_cnt    = 0;
                    rbg_idx   = exp_idx + 1;
                end else begin
                    re_cnt  = cur_cnt + 1;
                    rbg_idx = exp_idx;
                end
            end
        end
        if (i_row_done) begin
            $display("test %0d finished: %0d checks, %0d errors", i_row_id,
                     chk_cnt - row_chk, err_cnt - row_err);
            row_chk = chk_cnt;
            row_err = err_cnt;
        end
        if (i_all_done) begin
            $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
        end
    end

endmodule

// ==== dv/pusch_dr_sva.sv ====
// PUSCH DR strobe assertions
// power report pulse width, its offset from the RBG end,
// and framing flags only on valid beam samples
module pusch_dr_sva (
    input logic i_clk,
    input logic i_reset,
    input logic i_beam_vld,
    input logic i_rbg_start,
    input logic i_rbg_end,
    input logic i_pwr_vld
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    a_pwr_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pwr_vld |=> !i_pwr_vld)
        else begin
            $error("o_pwr_vld high for more than one cycle");
            fail_cnt++;
        end

    // registered end flag leads the report by 2 edges, 3 after the RE
    a_end_to_pwr: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_beam_vld && i_rbg_end) |-> ##2 i_pwr_vld)
        else begin
            $error("no o_pwr_vld after o_rbg_end");
            fail_cnt++;
        end

    a_pwr_from_end: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pwr_vld |-> $past(i_beam_vld && i_rbg_end, 2))
        else begin
            $error("o_pwr_vld without a matching o_rbg_end");
            fail_cnt++;
        end

    a_flags_vld: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rbg_start || i_rbg_end) |-> i_beam_vld)
        else begin
            $error("rbg flag without o_beam_vld");
            fail_cnt++;
        end

endmodule

bind pusch_dr_top pusch_dr_sva sva_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_beam_vld  (o_beam_vld),
    .i_rbg_start (o_rbg_start),
    .i_rbg_end   (o_rbg_end),
    .i_pwr_vld   (o_pwr_vld)
);

// ==== verilog/pusch_dr_top.sv ====
// PUSCH dimension-reduction top
// rbg_counter -> beam_mac -> beam_power_acc -> beam_select
// beam stream leaves 1 cycle after the input RE, RBG powers
// leave 3 cycles after the last RE of the RBG
module pusch_dr_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_iq_vld,
    input  logic                   i_iq_sop,
    input  dr_beam_pkg::ant_vec_t  i_iq_data,
    input  dr_cfg_pkg::rbg_size_t  i_rbg_size,
    // beam stream
    output logic                   o_beam_vld,
    output dr_beam_pkg::beam_vec_t o_beam_data,
    output logic                   o_rbg_start,
    output logic                   o_rbg_end,
    output dr_cfg_pkg::rbg_idx_t   o_rbg_idx,
    // per-RBG power report
    output logic                   o_pwr_vld,
    output dr_beam_pkg::pwr_vec_t  o_beam_pwr,
    output dr_beam_pkg::beam_idx_t o_best_beam,
    output dr_cfg_pkg::rbg_idx_t   o_pwr_rbg_idx
);
    import dr_cfg_pkg::*;
    import dr_beam_pkg::*;

    logic      re_first;
    logic      re_last;
    rbg_idx_t  re_rbg_idx;     // index of the RE on the input
    bsum_vec_t sum_i;
    bsum_vec_t sum_q;
    logic      acc_done;
    pwr_vec_t  acc_pwr;
    rbg_idx_t  acc_rbg_idx;

    // ----------------------------------------------------------
    // framing
    // ----------------------------------------------------------
    rbg_counter u_rbg_counter (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_iq_vld   (i_iq_vld),
        .i_iq_sop   (i_iq_sop),
        .i_rbg_size (i_rbg_size),
        .o_re_first (re_first),
        .o_re_last  (re_last),
        .o_rbg_idx  (re_rbg_idx)
    );

    // ----------------------------------------------------------
    // beamforming, feeds outputs and power path
    // ----------------------------------------------------------
    beam_mac u_beam_mac (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_iq_vld    (i_iq_vld),
        .i_iq_data   (i_iq_data),
        .i_re_first  (re_first),
        .i_re_last   (re_last),
        .i_rbg_idx   (re_rbg_idx),
        .o_vld       (o_beam_vld),
        .o_first     (o_rbg_start),
        .o_last      (o_rbg_end),
        .o_rbg_idx   (o_rbg_idx),
        .o_sum_i     (sum_i),
        .o_sum_q     (sum_q),
        .o_beam_data (o_beam_data)
    );

    // ----------------------------------------------------------
    // power and selection
    // ----------------------------------------------------------
    beam_power_acc u_beam_power_acc (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_vld     (o_beam_vld),
        .i_first   (o_rbg_start),
        .i_last    (o_rbg_end),
        .i_rbg_idx (o_rbg_idx),
        .i_sum_i   (sum_i),
        .i_sum_q   (sum_q),
        .o_done    (acc_done),
        .o_pwr     (acc_pwr),
        .o_rbg_idx (acc_rbg_idx)
    );

    beam_select u_beam_select (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_done      (acc_done),
        .i_pwr       (acc_pwr),
        .i_rbg_idx   (acc_rbg_idx),
        .o_pwr_vld   (o_pwr_vld),
        .o_beam_pwr  (o_beam_pwr),
        .o_best_beam (o_best_beam),
        .o_rbg_idx   (o_pwr_rbg_idx)
    );

endmodule

// ==== verilog/beam_select.sv ====
// Beam select
// latches the RBG beam powers and picks the strongest beam,
// lowest index wins a tie
`include "pusch_dr_params.svh"

module beam_select (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_done,
    input  dr_beam_pkg::pwr_vec_t  i_pwr,
    input  dr_cfg_pkg::rbg_idx_t   i_rbg_idx,
    output logic                   o_pwr_vld,
    output dr_beam_pkg::pwr_vec_t  o_beam_pwr,
    output dr_beam_pkg::beam_idx_t o_best_beam,
    output dr_cfg_pkg::rbg_idx_t   o_rbg_idx
);
    import dr_beam_pkg::*;

    beam_idx_t best;

    // argmax, strict compare keeps the lower index
    always_comb begin
        best = '0;
        for (int b = 1; b < `DR_BEAM; b++) begin
            if (i_pwr[b] > i_pwr[best]) begin
                best = beam_idx_t'(b);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_done) begin
            o_beam_pwr  <= i_pwr;
            o_best_beam <= best;
            o_rbg_idx   <= i_rbg_idx;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pwr_vld <= 1'b0;
        end else begin
            o_pwr_vld <= i_done;    // one pulse per RBG
        end
    end

endmodule

// ==== verilog/beam_power_acc.sv ====
// Beam power accumulator
// adds I^2 + Q^2 of each full-width beam sum over one RBG.
// the total, including the last RE, is registered with the RBG
// index and flagged by a one-cycle done pulse
`include "pusch_dr_params.svh"

module beam_power_acc (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_vld,
    input  logic                   i_first,
    input  logic                   i_last,
    input  dr_cfg_pkg::rbg_idx_t   i_rbg_idx,
    input  dr_beam_pkg::bsum_vec_t i_sum_i,
    input  dr_beam_pkg::bsum_vec_t i_sum_q,
    output logic                   o_done,
    output dr_beam_pkg::pwr_vec_t  o_pwr,
    output dr_cfg_pkg::rbg_idx_t   o_rbg_idx
);
    import dr_beam_pkg::*;

    localparam int SQW = 2 * `DR_BW;    // square width

    pwr_vec_t acc;
    pwr_vec_t acc_nxt;

    // ----------------------------------------------------------
    // RE power and running sum
    // ----------------------------------------------------------
    always_comb begin
        logic signed [SQW-1:0] ext_i;
        logic signed [SQW-1:0] ext_q;
        logic signed [SQW-1:0] sq_i;
        logic signed [SQW-1:0] sq_q;
        pwr_t                  re_pwr;
        for (int b = 0; b < `DR_BEAM; b++) begin
            ext_i = SQW'(i_sum_i[b]);
            ext_q = SQW'(i_sum_q[b]);
            sq_i  = ext_i * ext_i;    // < 2^35, never negative
            sq_q  = ext_q * ext_q;
            re_pwr = {{(`DR_PW - SQW){1'b0}}, sq_i}
                   + {{(`DR_PW - SQW){1'b0}}, sq_q};
            // first RE of an RBG drops the old sum
            acc_nxt[b] = (i_first ? '0 : acc[b]) + re_pwr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_vld) begin
            acc <= acc_nxt;
        end
        if (i_vld && i_last) begin
            o_pwr     <= acc_nxt;      // total incl. the last RE
            o_rbg_idx <= i_rbg_idx;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_vld && i_last;
        end
    end

endmodule

// ==== verilog/beam_mac.sv ====
// Beam MAC
// forms the Hadamard beams from the antenna samples of one RE.
// full-width sums go to the power path, the shifted sums form
// the output stream; one register stage
`include "pusch_dr_params.svh"

module beam_mac (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_iq_vld,
    input  dr_beam_pkg::ant_vec_t  i_iq_data,
    input  logic                   i_re_first,
    input  logic                   i_re_last,
    input  dr_cfg_pkg::rbg_idx_t   i_rbg_idx,
    output logic                   o_vld,
    output logic                   o_first,
    output logic                   o_last,
    output dr_cfg_pkg::rbg_idx_t   o_rbg_idx,
    output dr_beam_pkg::bsum_vec_t o_sum_i,
    output dr_beam_pkg::bsum_vec_t o_sum_q,
    output dr_beam_pkg::beam_vec_t o_beam_data
);
    import dr_beam_pkg::*;

    bsum_vec_t sum_i;
    bsum_vec_t sum_q;
    beam_vec_t beam_out;

    // ----------------------------------------------------------
    // signed add per beam, weights are +-1 only
    // ----------------------------------------------------------
    always_comb begin
        bsum_t ext_i;
        bsum_t ext_q;
        bsum_t shr_i;
        bsum_t shr_q;
        for (int b = 0; b < `DR_BEAM; b++) begin
            sum_i[b] = '0;
            sum_q[b] = '0;
            for (int a = 0; a < `DR_ANT; a++) begin
                ext_i = bsum_t'(i_iq_data[a].i);    // sign extend
                ext_q = bsum_t'(i_iq_data[a].q);
                if (HADAMARD_SIGN[b][a]) begin
                    sum_i[b] = sum_i[b] - ext_i;
                    sum_q[b] = sum_q[b] - ext_q;
                end else begin
                    sum_i[b] = sum_i[b] + ext_i;
                    sum_q[b] = sum_q[b] + ext_q;
                end
            end
            shr_i = sum_i[b] >>> `DR_SHIFT;
            shr_q = sum_q[b] >>> `DR_SHIFT;
            beam_out[b].i = shr_i[`DR_OW-1:0];
            beam_out[b].q = shr_q[`DR_OW-1:0];
        end
    end

    // strobes
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_vld   <= 1'b0;
            o_first <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_vld   <= i_iq_vld;
            o_first <= i_iq_vld && i_re_first;
            o_last  <= i_iq_vld && i_re_last;
        end
    end

    // payload, held over gaps
    always_ff @(posedge i_clk) begin
        if (i_iq_vld) begin
            o_rbg_idx   <= i_rbg_idx;
            o_sum_i     <= sum_i;
            o_sum_q     <= sum_q;
            o_beam_data <= beam_out;
        end
    end

endmodule

// ==== verilog/rbg_counter.sv ====
// RBG counter
// tracks the RE position inside the current RBG and the RBG index
// inside the symbol; flags first and last RE of each RBG.
// flags and index are combinational from the incoming RE
module rbg_counter (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_iq_vld,
    input  logic                  i_iq_sop,
    input  dr_cfg_pkg::rbg_size_t i_rbg_size,
    output logic                  o_re_first,
    output logic                  o_re_last,
    output dr_cfg_pkg::rbg_idx_t  o_rbg_idx
);
    import dr_cfg_pkg::*;

    re_cnt_t  re_cnt;       // position the next RE takes
    rbg_idx_t rbg_idx;
    re_cnt_t  cur_cnt;      // position of the RE on the input now
    rbg_idx_t cur_idx;
    re_cnt_t  rbg_len;

    // ----------------------------------------------------------
    // current RE position
    // ----------------------------------------------------------
    always_comb begin
        cur_cnt = i_iq_sop ? '0 : re_cnt;    // sop restarts both counts
        cur_idx = i_iq_sop ? '0 : rbg_idx;
        rbg_len = re_per_rbg(i_rbg_size);
    end

    assign o_re_first = i_iq_vld && (cur_cnt == '0);
    assign o_re_last  = i_iq_vld && (cur_cnt == rbg_len - 8'd1);
    assign o_rbg_idx  = cur_idx;

    // ----------------------------------------------------------
    // count registers, frozen on idle cycles
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            rbg_idx <= '0;
        end else if (i_iq_vld) begin
            if (o_re_last) begin
                re_cnt  <= '0;
                rbg_idx <= cur_idx + 8'd1;   // runs on until next sop
            end else begin
                re_cnt  <= cur_cnt + 8'd1;
                rbg_idx <= cur_idx;
            end
        end
    end

endmodule

// ==== verilog/dr_beam_pkg.sv ====
// PUSCH DR beam package
// antenna sample, beam sum, output beam and power types,
// plus the fixed 4x4 Hadamard codebook as sign bits
`include "pusch_dr_params.svh"

package dr_beam_pkg;

    // ----------------------------------------------------------
    // antenna side
    // ----------------------------------------------------------
    typedef struct packed {
        logic signed [`DR_IW-1:0] i;
        logic signed [`DR_IW-1:0] q;
    } iq_t;

    typedef iq_t [`DR_ANT-1:0] ant_vec_t;

    // ----------------------------------------------------------
    // beam side
    // ----------------------------------------------------------
    typedef logic signed [`DR_BW-1:0] bsum_t;      // full-width beam sum
    typedef bsum_t [`DR_BEAM-1:0]     bsum_vec_t;

    typedef struct packed {
        logic signed [`DR_OW-1:0] i;
        logic signed [`DR_OW-1:0] q;
    } beam_iq_t;

    typedef beam_iq_t [`DR_BEAM-1:0] beam_vec_t;

    typedef logic [`DR_PW-1:0]    pwr_t;
    typedef pwr_t [`DR_BEAM-1:0]  pwr_vec_t;

    typedef logic [1:0] beam_idx_t;

    // sylvester order, [beam][ant], 1 means weight -1
    // bit set when popcount(beam & ant) is odd
    localparam logic [`DR_BEAM-1:0][`DR_ANT-1:0] HADAMARD_SIGN = {
        4'b0110,    // beam 3: + - - +
        4'b1100,    // beam 2: + + - -
        4'b1010,    // beam 1: + - + -
        4'b0000     // beam 0: + + + +
    };

endpackage

// ==== verilog/dr_cfg_pkg.sv ====
// PUSCH DR configuration package
// RBG size code, index types and the RE count of an RBG
package dr_cfg_pkg;

    typedef logic [1:0] rbg_size_t;   // 0: 4 prb, 1: 8 prb, 2/3: 16 prb
    typedef logic [7:0] rbg_idx_t;    // rbg within a symbol
    typedef logic [7:0] re_cnt_t;     // re within an rbg

    // ----------------------------------------------------------
    // REs per RBG, 12 per PRB
    // ----------------------------------------------------------
    function automatic re_cnt_t re_per_rbg(input rbg_size_t size);
        re_cnt_t n;
        case (size)
            2'd0:    n = 8'd48;
            2'd1:    n = 8'd96;
            default: n = 8'd192;    // code 3 runs as 16 prb
        endcase
        return n;
    endfunction

endpackage

// ==== verilog/pusch_dr_params.svh ====
// PUSCH dimension-reduction parameters
// array sizes and datapath widths shared by RTL and testbench
`ifndef PUSCH_DR_PARAMS_SVH
`define PUSCH_DR_PARAMS_SVH

// ----------------------------------------------------------
// array size
// ----------------------------------------------------------
`define DR_ANT      4     // antennas on the lane
`define DR_BEAM     4     // hadamard beams

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------
`define DR_IW       16    // input I or Q
`define DR_BW       18    // full beam sum, IW + log2(ANT)
`define DR_OW       16    // output beam I or Q
`define DR_PW       48    // per-beam power accumulator

// beam sum to output, 18 -> 16 bits, always fits
`define DR_SHIFT    2

`endif
